// ==== design/dcp_pkg.sv ====
package dcp_pkg;

    // command codes out of the scanner
    typedef enum logic [2:0] {
        CMD_W,
        CMD_V,
        CMD_D,
        CMD_R,
        CMD_BAD
    } cmd_t;

    // ascii command letters
    localparam logic [7:0] CH_W   = 8'h57;
    localparam logic [7:0] CH_V   = 8'h56;
    localparam logic [7:0] CH_D   = 8'h44;
    localparam logic [7:0] CH_R   = 8'h52;

    localparam logic [7:0] CH_SP  = 8'h20;
    localparam logic [7:0] CH_CR  = 8'h0d;
    localparam logic [7:0] CH_LF  = 8'h0a;
    localparam logic [7:0] CH_OK  = 8'h4b; // 'K'
    localparam logic [7:0] CH_BAD = 8'h3f; // '?'

    // words per dump
    localparam logic [3:0] DUMP_LEN_D = 4'd4;
    localparam logic [3:0] DUMP_LEN_R = 4'd8;

    typedef enum logic [1:0] {ST_SCAN, ST_EXEC, ST_REPLY, ST_DUMP} dcp_state_t;

endpackage

// ==== design/dbg_pkg.sv ====
package dbg_pkg;

    localparam int WORD_W   = 32;

    localparam int DM_DEPTH = 16; // data memory words
    localparam int DM_AW    = 4;
    localparam int RF_DEPTH = 8;  // register file entries
    localparam int RF_AW    = 3;

endpackage

// ==== design/cmd_scan.sv ====
`timescale 1ns/10ps

module cmd_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         rx_data,
    input  logic               rx_valid,
    output logic               rx_ready,
    input  logic               scan_en,
    output logic               cmd_done,
    output dcp_pkg::cmd_t      cmd_code,
    output logic [31:0]        op_a,
    output logic [31:0]        op_b,
    output logic               has_a
);
    // position within the line
    typedef enum logic [1:0] {F_LET, F_CMD, F_A, F_B} field_t;

    field_t     field;
    logic       take;
    logic       hex_ok;
    logic [3:0] nib;

    // hold off while the finished line is handed over
    assign rx_ready = scan_en && !cmd_done;
    assign take     = rx_valid && rx_ready;

    // ascii hex to nibble, either case
    always_comb begin
        hex_ok = 1'b1;
        nib    = 4'h0;
        if (rx_data >= 8'h30 && rx_data <= 8'h39)
            nib = rx_data[3:0];
        else if ((rx_data >= 8'h41 && rx_data <= 8'h46) || (rx_data >= 8'h61 && rx_data <= 8'h66))
            nib = rx_data[3:0] + 4'd9; // low nibble of 'A' / 'a' is 1
        else
            hex_ok = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            field    <= F_LET;
            cmd_done <= 1'b0;
            cmd_code <= dcp_pkg::CMD_BAD;
            has_a    <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (take) begin
                if (rx_data == dcp_pkg::CH_CR) begin
                    if (field != F_LET) begin // blank lines are skipped
                        cmd_done <= 1'b1;
                        field    <= F_LET;
                    end
                end else if (field == F_LET) begin
                    if (rx_data != dcp_pkg::CH_LF && rx_data != dcp_pkg::CH_SP) begin
                        field <= F_CMD;
                        op_a  <= '0; // new line, fresh operands
                        op_b  <= '0;
                        has_a <= 1'b0;
                        case (rx_data)
                            dcp_pkg::CH_W: cmd_code <= dcp_pkg::CMD_W;
                            dcp_pkg::CH_V: cmd_code <= dcp_pkg::CMD_V;
                            dcp_pkg::CH_D: cmd_code <= dcp_pkg::CMD_D;
                            dcp_pkg::CH_R: cmd_code <= dcp_pkg::CMD_R;
                            default:       cmd_code <= dcp_pkg::CMD_BAD;
                        endcase
                    end
                end else if (rx_data == dcp_pkg::CH_SP) begin
                    if (field == F_CMD)
                        field <= F_A;
                    else if (field == F_A && has_a)
                        field <= F_B; // second operand follows
                end else if (hex_ok) begin
                    if (field == F_B) begin
                        op_b <= {op_b[27:0], nib};
                    end else begin
                        op_a  <= {op_a[27:0], nib};
                        has_a <= 1'b1;
                        field <= F_A;
                    end
                end
            end
        end
    end

endmodule

// ==== design/hex_sender.sv ====
`timescale 1ns/10ps

module hex_sender (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] word,
    input  logic        word_valid,
    output logic        word_ready,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    input  logic        tx_ready
);
    logic        busy;
    logic [3:0]  cnt;     // 0..7 hex digits, 8 is the space
    logic [31:0] shift_q; // top nibble is the current digit
    logic [3:0]  nib;

    assign word_ready = !busy;
    assign tx_valid   = busy;
    assign nib        = shift_q[31:28];

    always_comb begin
        if (cnt == 4'd8)
            tx_data = dcp_pkg::CH_SP;
        else if (nib < 4'd10)
            tx_data = {4'h0, nib} + 8'h30;
        else
            tx_data = {4'h0, nib} + 8'h37; // upper case A..F
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
        end else if (!busy) begin
            if (word_valid) begin
                busy    <= 1'b1;
                cnt     <= 4'd0;
                shift_q <= word;
            end
        end else if (tx_ready) begin
            if (cnt == 4'd8) begin
                busy <= 1'b0; // space taken, ready for the next word
            end else begin
                cnt     <= cnt + 4'd1;
                shift_q <= {shift_q[27:0], 4'h0};
            end
        end
    end

endmodule

// ==== design/dump_engine.sv ====
`timescale 1ns/10ps

module dump_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dump_start,
    input  logic                       dump_src,
    input  logic [dbg_pkg::DM_AW-1:0]  dump_addr,
    input  logic [3:0]                 dump_len,
    output logic                       dump_done,
    output logic                       rd_src,
    output logic [dbg_pkg::DM_AW-1:0]  rd_addr,
    input  logic [dbg_pkg::WORD_W-1:0] rd_data,
    output logic [7:0]                 tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready
);
    typedef enum logic [1:0] {E_IDLE, E_WORDS, E_CR, E_LF} eng_t;

    eng_t                      state;
    logic [dbg_pkg::DM_AW-1:0] addr;
    logic [dbg_pkg::DM_AW-1:0] addr_inc;
    logic [dbg_pkg::DM_AW-1:0] start_addr;
    logic [3:0]                left;     // words not yet handed to the sender
    logic                      word_valid;
    logic                      word_ready;
    logic [7:0]                snd_data;
    logic                      snd_valid;

    // register file wraps at 8, data memory at 16
    always_comb begin
        addr_inc = addr + 4'd1;
        if (rd_src)
            addr_inc[dbg_pkg::DM_AW-1:dbg_pkg::RF_AW] = '0;
    end

    always_comb begin
        start_addr = dump_addr;
        if (dump_src)
            start_addr[dbg_pkg::DM_AW-1:dbg_pkg::RF_AW] = '0;
    end

    assign rd_addr    = addr;
    assign word_valid = (state == E_WORDS) && (left != 4'd0);
    assign dump_done  = (state == E_LF) && tx_ready;

    hex_sender u_hex (
        .clk        (clk),
        .rst        (rst),
        .word       (rd_data),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .tx_data    (snd_data),
        .tx_valid   (snd_valid),
        .tx_ready   (tx_ready)
    );

    // line ending comes from here, words from the sender
    always_comb begin
        case (state)
            E_CR: begin
                tx_data  = dcp_pkg::CH_CR;
                tx_valid = 1'b1;
            end
            E_LF: begin
                tx_data  = dcp_pkg::CH_LF;
                tx_valid = 1'b1;
            end
            default: begin
                tx_data  = snd_data;
                tx_valid = snd_valid;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= E_IDLE;
            left   <= 4'd0;
            rd_src <= 1'b0;
        end else begin
            case (state)
                E_IDLE: if (dump_start) begin
                    state  <= E_WORDS;
                    addr   <= start_addr;
                    left   <= dump_len;
                    rd_src <= dump_src;
                end
                E_WORDS: begin
                    if (word_valid && word_ready) begin
                        addr <= addr_inc; // next read overlaps this word's output
                        left <= left - 4'd1;
                    end else if (left == 4'd0 && word_ready) begin
                        state <= E_CR; // last space is out
                    end
                end
                E_CR: if (tx_ready) state <= E_LF;
                E_LF: if (tx_ready) state <= E_IDLE;
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

// ==== design/dcp.sv ====
`timescale 1ns/10ps

module dcp (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 rx_data,
    input  logic                       rx_valid,
    output logic                       rx_ready,
    output logic [7:0]                 tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output logic                       dm_we,
    output logic                       rf_we,
    output logic [dbg_pkg::DM_AW-1:0]  wr_addr,
    output logic [dbg_pkg::WORD_W-1:0] wr_data,
    output logic                       rd_src,
    output logic [dbg_pkg::DM_AW-1:0]  rd_addr,
    input  logic [dbg_pkg::WORD_W-1:0] rd_data
);
    dcp_pkg::dcp_state_t       state;
    dcp_pkg::cmd_t             cmd_code;
    logic                      scan_rdy;
    logic                      cmd_done;
    logic [31:0]               op_a;
    logic [31:0]               op_b;
    logic                      has_a;
    logic                      is_dump;
    logic                      dump_start;
    logic                      dump_src;
    logic [dbg_pkg::DM_AW-1:0] dump_addr;
    logic [3:0]                dump_len;
    logic                      dump_done;
    logic [7:0]                eng_data;
    logic                      eng_valid;
    logic [dbg_pkg::DM_AW-1:0] next_addr; // where a bare D carries on
    logic [1:0]                rep_cnt;
    logic [7:0]                rep_data;

    cmd_scan u_scan (
        .clk (clk), .rst (rst),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (scan_rdy),
        .scan_en (state == dcp_pkg::ST_SCAN),
        .cmd_done (cmd_done), .cmd_code (cmd_code),
        .op_a (op_a), .op_b (op_b), .has_a (has_a)
    );

    dump_engine u_dump (
        .clk (clk), .rst (rst),
        .dump_start (dump_start), .dump_src (dump_src),
        .dump_addr (dump_addr), .dump_len (dump_len), .dump_done (dump_done),
        .rd_src (rd_src), .rd_addr (rd_addr), .rd_data (rd_data),
        .tx_data (eng_data), .tx_valid (eng_valid), .tx_ready (tx_ready)
    );

    assign is_dump    = (cmd_code == dcp_pkg::CMD_D) || (cmd_code == dcp_pkg::CMD_R);
    assign dm_we      = (state == dcp_pkg::ST_EXEC) && (cmd_code == dcp_pkg::CMD_W);
    assign rf_we      = (state == dcp_pkg::ST_EXEC) && (cmd_code == dcp_pkg::CMD_V);
    assign wr_addr    = op_a[dbg_pkg::DM_AW-1:0]; // target drops the top bit for registers
    assign wr_data    = op_b;
    assign dump_start = (state == dcp_pkg::ST_EXEC) && is_dump;
    assign dump_src   = (cmd_code == dcp_pkg::CMD_R);
    assign dump_len   = dump_src ? dcp_pkg::DUMP_LEN_R : dcp_pkg::DUMP_LEN_D;

    always_comb begin
        if (dump_src)
            dump_addr = '0;
        else if (has_a)
            dump_addr = op_a[dbg_pkg::DM_AW-1:0]; // modulo 16
        else
            dump_addr = next_addr;
    end

    always_comb begin
        case (rep_cnt)
            2'd0:    rep_data = (cmd_code == dcp_pkg::CMD_BAD) ? dcp_pkg::CH_BAD : dcp_pkg::CH_OK;
            2'd1:    rep_data = dcp_pkg::CH_CR;
            default: rep_data = dcp_pkg::CH_LF;
        endcase
    end

    // switch between the stream owners
    always_comb begin
        rx_ready = 1'b0;
        tx_data  = 8'h00;
        tx_valid = 1'b0;
        case (state)
            dcp_pkg::ST_SCAN:  rx_ready = scan_rdy;
            dcp_pkg::ST_REPLY: begin
                tx_data  = rep_data;
                tx_valid = 1'b1;
            end
            dcp_pkg::ST_DUMP:  begin
                tx_data  = eng_data;
                tx_valid = eng_valid;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dcp_pkg::ST_SCAN;
            next_addr <= '0;
            rep_cnt   <= 2'd0;
        end else begin
            case (state)
                dcp_pkg::ST_SCAN: if (cmd_done) state <= dcp_pkg::ST_EXEC;
                dcp_pkg::ST_EXEC: begin
                    rep_cnt <= 2'd0;
                    if (cmd_code == dcp_pkg::CMD_D)
                        next_addr <= dump_addr + dcp_pkg::DUMP_LEN_D; // wraps at 16
                    state <= is_dump ? dcp_pkg::ST_DUMP : dcp_pkg::ST_REPLY;
                end
                dcp_pkg::ST_REPLY: if (tx_ready) begin
                    if (rep_cnt == 2'd2)
                        state <= dcp_pkg::ST_SCAN;
                    else
                        rep_cnt <= rep_cnt + 2'd1;
                end
                dcp_pkg::ST_DUMP: if (dump_done) state <= dcp_pkg::ST_SCAN;
                default: state <= dcp_pkg::ST_SCAN;
            endcase
        end
    end

endmodule

// ==== design/dbg_target.sv ====
`timescale 1ns/10ps

module dbg_target (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dm_we,
    input  logic                       rf_we,
    input  logic [dbg_pkg::DM_AW-1:0]  wr_addr,
    input  logic [dbg_pkg::WORD_W-1:0] wr_data,
    input  logic                       rd_src,
    input  logic [dbg_pkg::DM_AW-1:0]  rd_addr,
    output logic [dbg_pkg::WORD_W-1:0] rd_data
);
    logic [dbg_pkg::WORD_W-1:0] dm [dbg_pkg::DM_DEPTH]; // data memory
    logic [dbg_pkg::WORD_W-1:0] rf [dbg_pkg::RF_DEPTH]; // register file

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dbg_pkg::DM_DEPTH; i++)
                dm[i] <= '0;
            for (int j = 0; j < dbg_pkg::RF_DEPTH; j++)
                rf[j] <= '0;
        end else begin
            if (dm_we)
                dm[wr_addr] <= wr_data;
            if (rf_we)
                rf[wr_addr[dbg_pkg::RF_AW-1:0]] <= wr_data;
        end
    end

    // async read, 1 selects the register file
    assign rd_data = rd_src ? rf[rd_addr[dbg_pkg::RF_AW-1:0]] : dm[rd_addr];

endmodule

// ==== design/dcp_top.sv ====
`timescale 1ns/10ps

module dcp_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);
    logic                       dm_we;
    logic                       rf_we;
    logic [dbg_pkg::DM_AW-1:0]  wr_addr;
    logic [dbg_pkg::WORD_W-1:0] wr_data;
    logic                       rd_src;
    logic [dbg_pkg::DM_AW-1:0]  rd_addr;
    logic [dbg_pkg::WORD_W-1:0] rd_data;

    dcp u_dcp (
        .clk (clk), .rst (rst),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (rx_ready),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready),
        .dm_we (dm_we), .rf_we (rf_we), .wr_addr (wr_addr), .wr_data (wr_data),
        .rd_src (rd_src), .rd_addr (rd_addr), .rd_data (rd_data)
    );

    dbg_target u_target (
        .clk (clk), .rst (rst),
        .dm_we (dm_we), .rf_we (rf_we), .wr_addr (wr_addr), .wr_data (wr_data),
        .rd_src (rd_src), .rd_addr (rd_addr), .rd_data (rd_data)
    );

endmodule

// ==== tb/tb_dcp.sv ====
`timescale 1ns/10ps

module tb_dcp;
    logic        clk;
    logic        rst;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;

    string       t_name[$];   // test table
    string       t_line[$];
    string       t_reply[$];
    logic [31:0] dm_model [16];
    logic [31:0] rf_model [8];
    logic [3:0]  next_d;      // where a bare D carries on
    logic [15:0] lfsr_q;
    int          cycle_cnt;
    int          cycle_limit;
    string       crlf;

    dcp_top UUT (
        .clk (clk), .rst (rst),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (rx_ready),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b      = lfsr_q[0];
    endtask

    task automatic rand_word(output logic [31:0] w);
        logic b;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            take_bit(b);
            w = {w[30:0], b};
        end
    endtask

    function automatic string hex_word(input logic [31:0] w);
        string s;
        s = $sformatf("%h", w);
        return s.toupper();
    endfunction

    // expected dump text, wrapping at the source depth
    function automatic string dump_reply(input logic src, input logic [3:0] start, input int len);
        string      s;
        logic [3:0] a;
        s = "";
        a = start;
        for (int k = 0; k < len; k++) begin
            if (src)
                s = $sformatf("%s%s ", s, hex_word(rf_model[a[2:0]]));
            else
                s = $sformatf("%s%s ", s, hex_word(dm_model[a]));
            a = src ? {1'b0, a[2:0] + 3'd1} : a + 4'd1;
        end
        return $sformatf("%s%s", s, crlf);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            report_failure($sformatf("ERROR %s: tx byte expected %h, got %h", name, exp, act));
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("ERROR %s: rx_ready expected %b, got %b", name, exp, act));
    endtask

    task automatic add_test(input string name, input string line, input string reply);
        t_name.push_back(name);
        t_line.push_back(line);
        t_reply.push_back(reply);
        cycle_limit += (line.len() + reply.len()) * 4;
    endtask

    task automatic add_write(input string name, input logic is_reg, input logic [3:0] addr,
                             input logic lower);
        logic [31:0] w;
        string       line;
        rand_word(w);
        if (is_reg) begin
            line = $sformatf("V %h %h", addr[2:0], w);
            rf_model[addr[2:0]] = w;
        end else begin
            line = $sformatf("W %h %h", addr, w);
            dm_model[addr] = w;
        end
        if (!lower)
            line = line.toupper();
        add_test(name, $sformatf("%s%c", line, 8'h0d), $sformatf("K%s", crlf));
    endtask

    task automatic add_dump(input string name, input logic has_op, input logic [7:0] op);
        logic [3:0] start;
        string      line;
        if (has_op) begin
            start = op[3:0]; // modulo 16
            line  = $sformatf("D %h%c", op, 8'h0d);
        end else begin
            start = next_d;
            line  = $sformatf("D%c", 8'h0d);
        end
        add_test(name, line, dump_reply(1'b0, start, 4));
        next_d = start + 4'd4;
    endtask

    // inputs change 1 ns after the edge, stall bit drawn every cycle
    task automatic next_cycle();
        logic b;
        @(posedge clk);
        #1;
        take_bit(b);
        tx_ready = ~b;
    endtask

    task automatic send_line(input string name, input string line);
        for (int i = 0; i < line.len(); i++) begin
            rx_data  = line[i];
            rx_valid = 1'b1;
            @(negedge clk);
            while (!rx_ready) begin
                next_cycle();
                @(negedge clk);
            end
            if (tx_valid)
                report_failure($sformatf("%s: tx byte offered while a line was received", name));
            next_cycle();
        end
        rx_valid = 1'b0;
    endtask

    task automatic collect_reply(input string name, input string reply);
        int idx;
        idx = 0;
        while (idx < reply.len()) begin
            @(negedge clk);
            check_ready(name, 1'b0, rx_ready); // no input until LF is gone
            if (tx_valid && tx_ready) begin
                check_byte(name, reply[idx], tx_data);
                idx++;
            end
            next_cycle();
        end
        @(negedge clk);
        check_ready(name, 1'b1, rx_ready);
        next_cycle();
    endtask

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit)
                report_failure($sformatf("timeout, no reply finished within %0d cycles",
                                         cycle_limit));
        end
    end

    initial begin
        rst         = 1'b1;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        tx_ready    = 1'b0;
        lfsr_q      = 16'd33;
        next_d      = 4'd0;
        cycle_limit = 100;
        crlf        = $sformatf("%c%c", 8'h0d, 8'h0a);
        dm_model    = '{default: 32'h0};
        rf_model    = '{default: 32'h0};

        add_dump("dump_after_reset", 1'b1, 8'h00);
        add_write("w_e_upper", 1'b0, 4'he, 1'b0);
        add_write("w_f_upper", 1'b0, 4'hf, 1'b0);
        add_write("w_0_lower", 1'b0, 4'h0, 1'b1);
        add_write("w_1_lower", 1'b0, 4'h1, 1'b1);
        add_write("w_5_upper", 1'b0, 4'h5, 1'b0);
        add_dump("dump_wrap", 1'b1, 8'h1e); // 14, 15, 0, 1
        add_dump("dump_cont_1", 1'b0, 8'h00);
        add_dump("dump_cont_2", 1'b0, 8'h00);
        add_write("v_3_upper", 1'b1, 4'h3, 1'b0);
        add_write("v_7_lower", 1'b1, 4'h7, 1'b1);
        add_write("v_0_upper", 1'b1, 4'h0, 1'b0);
        add_test("reg_dump", $sformatf("R%c", 8'h0d), dump_reply(1'b1, 4'h0, 8));
        add_test("bad_letter", $sformatf("X 12%c", 8'h0d), $sformatf("?%s", crlf));
        add_test("bad_lower_d", $sformatf("d%c", 8'h0d), $sformatf("?%s", crlf));
        add_dump("dump_cont_3", 1'b0, 8'h00); // bad lines leave the address alone

        repeat (2) next_cycle();
        rst = 1'b0;
        @(negedge clk);
        check_ready("after_reset", 1'b1, rx_ready);
        if (tx_valid)
            report_failure("tx_valid is high right after reset");
        next_cycle();

        for (int i = 0; i < t_line.size(); i++) begin
            send_line(t_name[i], t_line[i]);
            collect_reply(t_name[i], t_reply[i]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== dcp_debug.f ====
design/dcp_pkg.sv
design/dbg_pkg.sv
design/cmd_scan.sv
design/hex_sender.sv
design/dump_engine.sv
design/dcp.sv
design/dbg_target.sv
design/dcp_top.sv
tb/tb_dcp.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dcp testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_dcp -f dcp_debug.f -o sim_dcp; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_dcp)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** PASSED ***" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
